// ==== verilog/cdStreamPkg.sv ====
`default_nettype none

package cdStreamPkg;

	// One 16-bit word as delivered by the drive
	typedef logic [15:0] cdSampleT;

	// Word in flight between framer and router
	typedef struct packed {
		cdSampleT data;
		logic     audio;
		logic     valid;
		logic     header;
	} cdWordT;

	// Sector framing, counted in 16-bit words
	localparam int sectorWords = 1176;
	localparam int wordIdxBits = 11;
	localparam int syncWords   = 5;
	localparam int headerWord  = 7;

	typedef logic [wordIdxBits-1:0] wordIdxT;

	localparam wordIdxT lastWordIdx = wordIdxT'(sectorWords - 1);
	localparam wordIdxT syncIdx     = wordIdxT'(syncWords);
	localparam wordIdxT headerIdx   = wordIdxT'(headerWord);

	// Drive sends data words big-endian
	function automatic cdSampleT byteSwap(input cdSampleT w);
		return {w[7:0], w[15:8]};
	endfunction

endpackage

`default_nettype wire

// ==== verilog/shBusPkg.sv ====
`default_nettype none

package shBusPkg;

	typedef logic [4:0]  shAddrT;
	typedef logic [15:0] shDataT;

	// One recognized CPU access
	typedef struct packed {
		shAddrT addr;
		shDataT wdata;
		logic   wrPulse;
		logic   rdPulse;
	} shReqT;

	// Register map
	localparam shAddrT regFifoData = 5'h00;
	localparam shAddrT regTrCtl    = 5'h02;
	localparam shAddrT regIrqFlags = 5'h04;
	localparam shAddrT regIrqMask  = 5'h08;
	localparam shAddrT regStatus   = 5'h1A;

	// Transfer control
	localparam int     trCtlCaptureBit = 0;
	localparam int     trCtlClearBit   = 1;
	localparam int     trCtlDreqBit    = 2;
	localparam shDataT trCtlWMask      = 16'h0007;

	// Interrupt flags and status
	localparam int irqBits        = 8;
	localparam int irqOverflowBit = 0;
	localparam int irqHeaderBit   = 4;
	localparam int statusSyncBit  = 7;

	typedef logic [irqBits-1:0] irqVecT;

	// Sector FIFO sizing
	localparam int fifoDepth     = 8;
	localparam int fifoPtrBits   = 3;
	localparam int fifoCountBits = 4;
	localparam int fifoDreqLevel = 4;

	typedef logic [fifoPtrBits-1:0]   fifoPtrT;
	typedef logic [fifoCountBits-1:0] fifoCountT;

endpackage

`default_nettype wire

// ==== verilog/cdSectorFramer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdSectorFramer (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire cdStreamPkg::cdSampleT cdData,
	input  wire                        cdStrobe,
	input  wire                        cdAudio,
	output cdStreamPkg::cdWordT        framedWord,
	output logic                       framedValid,
	output logic                       syncEvt
);
	import cdStreamPkg::*;

	wordIdxT wordIdx;
	logic    synced;
	logic    dataStrobe;

	assign dataStrobe = cdStrobe && !cdAudio;

	// Word counter and sync state, audio words leave them alone
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wordIdx     <= '0;
			synced      <= 1'b0;
			framedValid <= 1'b0;
			syncEvt     <= 1'b0;
		end else begin
			framedValid <= cdStrobe;
			syncEvt     <= 1'b0;
			if (dataStrobe) begin
				wordIdx <= wordIdx + 1'b1;
				if (!synced) begin
					if (wordIdx == syncIdx) begin
						synced  <= 1'b1;
						syncEvt <= 1'b1;
					end
				end else if (wordIdx == lastWordIdx) begin
					// End of sector, hunt for the next sync
					synced  <= 1'b0;
					wordIdx <= '0;
				end
			end
		end
	end

	// Sync word itself is not payload, only words after it
	always_ff @(posedge CLK) begin
		if (cdStrobe) begin
			framedWord.data   <= cdData;
			framedWord.audio  <= cdAudio;
			framedWord.valid  <= !cdAudio && synced;
			framedWord.header <= !cdAudio && synced && (wordIdx == headerIdx);
		end
	end

	// Once synced the index sits past sync and inside the sector
	syncedIndexInRange: assert property (
		@(posedge CLK) disable iff (!RST_N)
		synced |-> (wordIdx > syncIdx) && (wordIdx <= lastWordIdx)
	);

endmodule

`default_nettype wire

// ==== verilog/cdWordRouter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdWordRouter (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire cdStreamPkg::cdWordT   framedWord,
	input  wire                        framedValid,
	output cdStreamPkg::cdSampleT      audioL,
	output cdStreamPkg::cdSampleT      audioR,
	output cdStreamPkg::cdSampleT      pushData,
	output logic                       pushValid,
	output logic                       headerEvt
);
	import cdStreamPkg::*;

	// Next audio word goes to the right channel
	logic rightNext;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			audioL    <= '0;
			audioR    <= '0;
			rightNext <= 1'b0;
			pushValid <= 1'b0;
			headerEvt <= 1'b0;
		end else begin
			pushValid <= 1'b0;
			headerEvt <= 1'b0;
			if (framedValid) begin
				if (framedWord.audio) begin
					rightNext <= !rightNext;
					if (rightNext) begin
						audioR <= framedWord.data;
					end else begin
						audioL <= framedWord.data;
					end
				end else begin
					// Data mode mutes both channels
					audioL    <= '0;
					audioR    <= '0;
					rightNext <= 1'b0;
					pushValid <= framedWord.valid;
					headerEvt <= framedWord.header;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (framedValid && framedWord.valid) begin
			pushData <= byteSwap(framedWord.data);
		end
	end

endmodule

`default_nettype wire

// ==== verilog/sectorFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module sectorFifo (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire cdStreamPkg::cdSampleT pushData,
	input  wire                        pushValid,
	input  wire                        popReq,
	input  wire                        fifoClear,
	input  wire                        captureEn,
	output cdStreamPkg::cdSampleT      popData,
	output shBusPkg::fifoCountT        fillCount,
	output logic                       overflowEvt
);
	import cdStreamPkg::*;
	import shBusPkg::*;

	cdSampleT mem [fifoDepth];
	fifoPtrT  wrPtr;
	fifoPtrT  rdPtr;
	logic     full;
	logic     empty;
	logic     pushReq;
	logic     doPush;
	logic     doPop;

	assign full    = fillCount == fifoCountT'(fifoDepth);
	assign empty   = fillCount == '0;
	assign pushReq = pushValid && captureEn;
	assign doPush  = pushReq && !full;
	assign doPop   = popReq && !empty;

	// Head word, zero when nothing is queued
	assign popData = empty ? '0 : mem[rdPtr];

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			fillCount   <= '0;
			overflowEvt <= 1'b0;
		end else if (fifoClear) begin
			wrPtr       <= '0;
			rdPtr       <= '0;
			fillCount   <= '0;
			overflowEvt <= 1'b0;
		end else begin
			// Dropped push when full
			overflowEvt <= pushReq && full;
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:   fillCount <= fillCount + 1'b1;
				2'b01:   fillCount <= fillCount - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (doPush && !fifoClear) begin
			mem[wrPtr] <= pushData;
		end
	end

	fillCountInRange: assert property (
		@(posedge CLK) disable iff (!RST_N)
		fillCount <= fifoCountT'(fifoDepth)
	);

	// Full ring has both pointers together, and the dropped word leaves them there
	overflowOnlyWhenFull: assert property (
		@(posedge CLK) disable iff (!RST_N)
		overflowEvt |-> $past(wrPtr == rdPtr) && (wrPtr == $past(wrPtr))
	);

endmodule

`default_nettype wire

// ==== verilog/shRegisterPort.sv ====
`timescale 1ns/1ps
`default_nettype none

module shRegisterPort (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire shBusPkg::shReqT       busReq,
	input  wire cdStreamPkg::cdSampleT popData,
	input  wire shBusPkg::fifoCountT   fillCount,
	input  wire                        overflowEvt,
	input  wire                        headerEvt,
	input  wire                        syncEvt,
	output shBusPkg::shDataT           rdata,
	output logic                       popReq,
	output logic                       fifoClear,
	output logic                       captureEn,
	output logic                       irqN,
	output logic                       dreqN
);
	import shBusPkg::*;

	shDataT trCtl;
	irqVecT irqFlags;
	irqVecT irqNext;
	irqVecT irqMask;
	logic   syncSeen;
	logic   readHit;
	shDataT statusWord;

	// Write wins when both strobes fall together
	assign readHit    = busReq.rdPulse && !busReq.wrPulse;
	assign popReq     = readHit && (busReq.addr == regFifoData);
	assign fifoClear  = busReq.wrPulse && (busReq.addr == regTrCtl)
		&& busReq.wdata[trCtlClearBit];
	assign captureEn  = trCtl[trCtlCaptureBit];
	assign statusWord = shDataT'(syncSeen) << statusSyncBit;

	assign irqN  = ~|(irqFlags & irqMask);
	assign dreqN = !(trCtl[trCtlDreqBit] && (fillCount >= fifoCountT'(fifoDreqLevel)));

	// Events set flags after the CPU clear, so a same-cycle event is kept
	always_comb begin
		irqNext = irqFlags;
		if (busReq.wrPulse && (busReq.addr == regIrqFlags)) begin
			irqNext = irqNext & busReq.wdata[irqBits-1:0];
		end
		if (headerEvt) begin
			irqNext[irqHeaderBit] = 1'b1;
		end
		if (overflowEvt) begin
			irqNext[irqOverflowBit] = 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			trCtl    <= '0;
			irqFlags <= '0;
			irqMask  <= '0;
			syncSeen <= 1'b0;
			rdata    <= '0;
		end else begin
			irqFlags <= irqNext;
			if (syncEvt) begin
				syncSeen <= 1'b1;
			end
			if (busReq.wrPulse) begin
				case (busReq.addr)
					regTrCtl: begin
						trCtl                <= busReq.wdata & trCtlWMask;
						trCtl[trCtlClearBit] <= 1'b0;
					end
					regIrqMask: irqMask <= busReq.wdata[irqBits-1:0];
					default: ;
				endcase
			end else if (readHit) begin
				case (busReq.addr)
					regFifoData: rdata <= popData;
					regTrCtl:    rdata <= trCtl;
					regIrqFlags: rdata <= shDataT'(irqFlags);
					regIrqMask:  rdata <= shDataT'(irqMask);
					regStatus:   rdata <= statusWord;
					default:     rdata <= '0;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/cdBlockBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdBlockBridge (
	input  wire                        CLK,
	input  wire                        RST_N,
	input  wire cdStreamPkg::cdSampleT cdData,
	input  wire                        cdStrobe,
	input  wire                        cdAudio,
	input  wire shBusPkg::shAddrT      addr,
	input  wire shBusPkg::shDataT      wdata,
	input  wire                        wrN,
	input  wire                        rdN,
	output shBusPkg::shDataT           rdata,
	output logic                       irqN,
	output logic                       dreqN,
	output cdStreamPkg::cdSampleT      audioL,
	output cdStreamPkg::cdSampleT      audioR
);
	import cdStreamPkg::*;
	import shBusPkg::*;

	cdWordT    framedWord;
	logic      framedValid;
	logic      syncEvt;
	cdSampleT  pushData;
	logic      pushValid;
	logic      headerEvt;
	cdSampleT  popData;
	fifoCountT fillCount;
	logic      overflowEvt;
	logic      popReq;
	logic      fifoClear;
	logic      captureEn;
	shReqT     busReq;
	logic      wrNOld;
	logic      rdNOld;

	// Bus strobe history for falling-edge detection
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wrNOld <= 1'b1;
			rdNOld <= 1'b1;
		end else begin
			wrNOld <= wrN;
			rdNOld <= rdN;
		end
	end

	assign busReq.addr    = addr;
	assign busReq.wdata   = wdata;
	assign busReq.wrPulse = !wrN && wrNOld;
	assign busReq.rdPulse = !rdN && rdNOld;

	cdSectorFramer framer (
		.CLK(CLK), .RST_N(RST_N),
		.cdData(cdData), .cdStrobe(cdStrobe), .cdAudio(cdAudio),
		.framedWord(framedWord), .framedValid(framedValid), .syncEvt(syncEvt)
	);

	cdWordRouter router (
		.CLK(CLK), .RST_N(RST_N),
		.framedWord(framedWord), .framedValid(framedValid),
		.audioL(audioL), .audioR(audioR),
		.pushData(pushData), .pushValid(pushValid), .headerEvt(headerEvt)
	);

	sectorFifo fifo (
		.CLK(CLK), .RST_N(RST_N),
		.pushData(pushData), .pushValid(pushValid),
		.popReq(popReq), .fifoClear(fifoClear), .captureEn(captureEn),
		.popData(popData), .fillCount(fillCount), .overflowEvt(overflowEvt)
	);

	shRegisterPort port (
		.CLK(CLK), .RST_N(RST_N),
		.busReq(busReq), .popData(popData), .fillCount(fillCount),
		.overflowEvt(overflowEvt), .headerEvt(headerEvt), .syncEvt(syncEvt),
		.rdata(rdata), .popReq(popReq), .fifoClear(fifoClear),
		.captureEn(captureEn), .irqN(irqN), .dreqN(dreqN)
	);

endmodule

`default_nettype wire

// ==== testbench/cdBlockBridgeTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdBlockBridgeTb;
	import cdStreamPkg::*;
	import shBusPkg::*;

	typedef enum logic [2:0] {
		idle,
		cdAudioWord,
		cdDataWord,
		cpuWrite,
		cpuRead
	} stepOpT;

	// One table row with the values expected once the step has settled
	typedef struct packed {
		stepOpT   op;
		shAddrT   addr;
		shDataT   value;
		shDataT   expRdata;
		cdSampleT expAudioL;
		cdSampleT expAudioR;
		logic     expIrqN;
		logic     expDreqN;
	} stepT;

	logic     CLK;
	logic     RST_N;
	cdSampleT cdData;
	logic     cdStrobe;
	logic     cdAudio;
	shAddrT   addr;
	shDataT   wdata;
	logic     wrN;
	logic     rdN;
	shDataT   rdata;
	logic     irqN;
	logic     dreqN;
	cdSampleT audioL;
	cdSampleT audioR;

	stepT        steps[$];
	logic [31:0] rngState;
	int          cycleCount;
	int          cycleLimit;

	// Reference model state
	shDataT   fifoQ[$];
	int       wordIdxM;
	logic     syncedM;
	logic     syncSeenM;
	logic     rightNextM;
	cdSampleT audioLM;
	cdSampleT audioRM;
	shDataT   ctlM;
	irqVecT   irqFlagsM;
	irqVecT   irqMaskM;

	cdBlockBridge DUT (
		.CLK(CLK), .RST_N(RST_N),
		.cdData(cdData), .cdStrobe(cdStrobe), .cdAudio(cdAudio),
		.addr(addr), .wdata(wdata), .wrN(wrN), .rdN(rdN),
		.rdata(rdata), .irqN(irqN), .dreqN(dreqN),
		.audioL(audioL), .audioR(audioR)
	);

	always #50 CLK = ~CLK;

	always @(posedge CLK) begin
		cycleCount = cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("Timeout: the run did not finish within %0d clock cycles", cycleLimit);
			$display("CHECKS FAILED");
			$fatal(1, "Timeout");
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic checkValue(input shDataT actual, input shDataT expected, input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Mismatch on %s", what);
		end
	endtask

	// Runs the model for one step and stores the row
	task automatic appendStep(input stepOpT op, input shAddrT a, input shDataT v);
		stepT   s;
		logic   isValid;
		logic   isHeader;
		shDataT rd;
		rd = '0;
		case (op)
			cdAudioWord: begin
				if (rightNextM) begin
					audioRM = v;
				end else begin
					audioLM = v;
				end
				rightNextM = !rightNextM;
			end
			cdDataWord: begin
				isValid  = syncedM;
				isHeader = syncedM && (wordIdxM == headerWord);
				if (!syncedM && wordIdxM == syncWords) begin
					syncedM   = 1'b1;
					syncSeenM = 1'b1;
					wordIdxM  = wordIdxM + 1;
				end else if (syncedM && wordIdxM == sectorWords - 1) begin
					syncedM  = 1'b0;
					wordIdxM = 0;
				end else begin
					wordIdxM = wordIdxM + 1;
				end
				audioLM    = '0;
				audioRM    = '0;
				rightNextM = 1'b0;
				if (isValid && ctlM[trCtlCaptureBit]) begin
					if (fifoQ.size() < fifoDepth) begin
						fifoQ.push_back({v[7:0], v[15:8]});
					end else begin
						irqFlagsM[irqOverflowBit] = 1'b1;
					end
				end
				if (isHeader) begin
					irqFlagsM[irqHeaderBit] = 1'b1;
				end
			end
			cpuWrite: begin
				case (a)
					regTrCtl: begin
						ctlM = v & trCtlWMask;
						ctlM[trCtlClearBit] = 1'b0;
						if (v[trCtlClearBit]) begin
							fifoQ.delete();
						end
					end
					regIrqFlags: irqFlagsM = irqFlagsM & v[irqBits-1:0];
					regIrqMask:  irqMaskM = v[irqBits-1:0];
					default: ;
				endcase
			end
			cpuRead: begin
				case (a)
					regFifoData: begin
						if (fifoQ.size() > 0) begin
							rd = fifoQ.pop_front();
						end
					end
					regTrCtl:    rd = ctlM;
					regIrqFlags: rd = shDataT'(irqFlagsM);
					regIrqMask:  rd = shDataT'(irqMaskM);
					regStatus:   rd = shDataT'(syncSeenM) << statusSyncBit;
					default:     rd = '0;
				endcase
			end
			default: ;
		endcase
		s.op        = op;
		s.addr      = a;
		s.value     = v;
		s.expRdata  = rd;
		s.expAudioL = audioLM;
		s.expAudioR = audioRM;
		s.expIrqN   = ~|(irqFlagsM & irqMaskM);
		s.expDreqN  = !(ctlM[trCtlDreqBit] && fifoQ.size() >= fifoDreqLevel);
		steps.push_back(s);
	endtask

	task automatic addRandomDataWords(input int count);
		int k;
		for (k = 0; k < count; k++) begin
			rngState = xorshift(rngState);
			appendStep(cdDataWord, '0, rngState[15:0]);
		end
	endtask

	task automatic buildTable();
		int k;
		// Reset values
		appendStep(idle, '0, '0);
		appendStep(cpuRead, regStatus, '0);
		appendStep(cpuRead, regFifoData, '0);
		appendStep(cpuRead, regIrqFlags, '0);
		appendStep(cpuRead, regTrCtl, '0);
		appendStep(cpuWrite, regTrCtl, 16'h0001);
		// Left, right, then a data word mutes both
		for (k = 0; k < 2; k++) begin
			rngState = xorshift(rngState);
			appendStep(cdAudioWord, '0, rngState[15:0]);
		end
		addRandomDataWords(5);
		appendStep(cpuRead, regStatus, '0);
		addRandomDataWords(1);
		appendStep(cpuRead, regStatus, '0);
		// Two payload words, the second is the header
		addRandomDataWords(2);
		appendStep(cpuRead, regIrqFlags, '0);
		appendStep(cpuWrite, regIrqMask, 16'h0010);
		appendStep(cpuWrite, regIrqFlags, 16'hFFEF);
		appendStep(cpuRead, regIrqFlags, '0);
		appendStep(cpuRead, regFifoData, '0);
		appendStep(cpuRead, regFifoData, '0);
		appendStep(cpuRead, regFifoData, '0);
		// DMA request at four queued words
		appendStep(cpuWrite, regTrCtl, 16'h0005);
		addRandomDataWords(4);
		appendStep(cpuRead, regFifoData, '0);
		// Fill to eight and push two more
		addRandomDataWords(7);
		appendStep(cpuRead, regIrqFlags, '0);
		// Drain the eight kept words, the read after them finds it empty
		for (k = 0; k < fifoDepth + 1; k++) begin
			appendStep(cpuRead, regFifoData, '0);
		end
		addRandomDataWords(2);
		appendStep(cpuWrite, regTrCtl, 16'h0007);
		appendStep(cpuRead, regFifoData, '0);
		appendStep(cpuRead, regTrCtl, '0);
		appendStep(cpuRead, regIrqMask, '0);
		appendStep(idle, '0, '0);
	endtask

	task automatic applyStep(input stepT s);
		@(negedge CLK);
		case (s.op)
			cdAudioWord, cdDataWord: begin
				cdData   = s.value;
				cdAudio  = (s.op == cdAudioWord);
				cdStrobe = 1'b1;
			end
			cpuWrite: begin
				addr  = s.addr;
				wdata = s.value;
				wrN   = 1'b0;
			end
			cpuRead: begin
				addr = s.addr;
				rdN  = 1'b0;
			end
			default: ;
		endcase
		@(negedge CLK);
		cdStrobe = 1'b0;
		wrN      = 1'b1;
		rdN      = 1'b1;
		// Longest path is an overflow flag, three edges after the strobe
		repeat (3) @(negedge CLK);
		if (s.op == cpuRead) begin
			checkValue(rdata, s.expRdata, $sformatf("rdata of register %02h", s.addr));
		end
		checkValue(audioL, s.expAudioL, "audioL");
		checkValue(audioR, s.expAudioR, "audioR");
		checkValue(shDataT'(irqN), shDataT'(s.expIrqN), "irqN");
		checkValue(shDataT'(dreqN), shDataT'(s.expDreqN), "dreqN");
	endtask

	initial begin
		int i;
		CLK        = 1'b0;
		RST_N      = 1'b0;
		cdData     = '0;
		cdStrobe   = 1'b0;
		cdAudio    = 1'b0;
		addr       = '0;
		wdata      = '0;
		wrN        = 1'b1;
		rdN        = 1'b1;
		cycleCount = 0;
		cycleLimit = 0;
		rngState   = 32'd42;
		wordIdxM   = 0;
		syncedM    = 1'b0;
		syncSeenM  = 1'b0;
		rightNextM = 1'b0;
		audioLM    = '0;
		audioRM    = '0;
		ctlM       = '0;
		irqFlagsM  = '0;
		irqMaskM   = '0;
		buildTable();
		cycleLimit = steps.size() * 6 + 50;
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		for (i = 0; i < steps.size(); i++) begin
			applyStep(steps[i]);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== cdBlockBridge.f ====
verilog/cdStreamPkg.sv
verilog/shBusPkg.sv
verilog/cdSectorFramer.sv
verilog/cdWordRouter.sv
verilog/sectorFifo.sv
verilog/shRegisterPort.sv
verilog/cdBlockBridge.sv
testbench/cdBlockBridgeTb.sv

// ==== runSim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cdBlockBridgeTb \
	-f cdBlockBridge.f -Mdir obj_dir

simOut=$(./obj_dir/VcdBlockBridgeTb || true)
echo "$simOut"

if echo "$simOut" | grep -q "ALL CHECKS PASSED"; then
	exit 0
fi
echo "Simulation did not pass"
exit 1
